// ==== vlog.f ====
verilog/phold_pkg.sv
verilog/core_if.sv
verilog/lfsr_rng.sv
verilog/rr_arbiter.sv
verilog/event_queue.sv
verilog/phold_core.sv
verilog/gvt_tracker.sv
verilog/event_scheduler.sv
verilog/phold_top.sv
tb/phold_tb.sv

// ==== tb/phold_tb.sv ====
module phold_tb import phold_pkg::*;;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_CORE     = 4;
   localparam int NUM_LP       = 16;
   localparam int SIM_END_TIME = 200;
   localparam int MIN_STEP     = 1;   // child lands 1 to 8 after its parent
   localparam int MAX_STEP     = 8;
   localparam int HALF_PERIOD  = 50;

   logic      clk   = 1'b0;
   logic      rst_n = 1'b0;
   sim_time_t gvt;
   logic      rtn_vld;
   logic      enq_vld;
   lp_id_t    enq_lp;
   sim_time_t enq_time;
   logic      deq_vld;
   lp_id_t    deq_lp;
   sim_time_t deq_time;

   // reference model
   int model_lp [$];
   int model_time [$];      // queued events in store order
   int parents [$];         // times of all events dispatched this run
   int children [$];        // times of all new events this run
   int out_min   = -1;      // smallest outstanding time, -1 when none
   int min_prev1 = -1;
   int min_prev2 = -1;

   bit in_init = 1'b1;
   bit in_run;
   bit after_rst;
   bit prev_strobe;
   bit gvt_valid;
   bit wait_restart;
   int init_cnt;
   int settle;              // samples since the last init enqueue
   int since_rtn;
   int gvt_last;
   int gvt_prev;
   int n_runs = 0;
   int runs_done;
   int init_runs;
   int n_enq;
   int n_deq;
   int errors;

   phold_top #(
      .NUM_CORE     (NUM_CORE),
      .NUM_LP       (NUM_LP),
      .SIM_END_TIME (SIM_END_TIME)
   ) u_phold_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .gvt      (gvt),
      .rtn_vld  (rtn_vld),
      .enq_vld  (enq_vld),
      .enq_lp   (enq_lp),
      .enq_time (enq_time),
      .deq_vld  (deq_vld),
      .deq_lp   (deq_lp),
      .deq_time (deq_time)
   );

   always #HALF_PERIOD clk = ~clk;

   task automatic check_eq(string name, int expected, int actual);
      assert (expected == actual)
      else begin
         $display("[FAIL] %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_range(string name, int lo, int hi, int actual);
      assert (actual >= lo && actual <= hi)
      else begin
         $display("[FAIL] %0d ns: %s expected %0d..%0d, got %0d",
                  $time, name, lo, hi, actual);
         errors++;
      end
   endtask

   task automatic check_true(bit cond, string what);
      assert (cond)
      else begin
         $display("error at %0d ns: %s", $time, what);
         errors++;
      end
   endtask

   task automatic check_quiet();
      check_eq("rtn_vld", 0, rtn_vld);
      check_eq("enq_vld", 0, enq_vld);
      check_eq("deq_vld", 0, deq_vld);
      check_eq("gvt", 0, gvt);
   endtask

   // minimum time in the model queue, earliest stored wins ties
   function automatic int queue_min_idx();
      int best;
      best = 0;
      for (int i = 1; i < model_time.size(); i++) begin
         if (model_time[i] < model_time[best])
            best = i;
      end
      return best;
   endfunction

   // pairs every new event with a parent 1 to 8 earlier
   // greedy over sorted times, smallest usable parent first
   function automatic bit match_parents(output int min_left);
      int p [$];
      int c [$];
      int j;
      bit ok;
      p = parents;
      c = children;
      p.sort();
      c.sort();
      j        = 0;
      ok       = 1'b1;
      min_left = -1;
      foreach (c[k]) begin
         while (j < p.size() && p[j] < c[k] - MAX_STEP) begin
            if (min_left < 0)
               min_left = p[j];   // too old for any later child
            j++;
         end
         if (j < p.size() && p[j] <= c[k] - MIN_STEP)
            j++;
         else
            ok = 1'b0;
      end
      if (min_left < 0 && j < p.size())
         min_left = p[j];
      return ok;
   endfunction

   function automatic int model_min();
      int m;
      m = out_min;
      foreach (model_time[i]) begin
         if (m < 0 || model_time[i] < m)
            m = model_time[i];
      end
      return m;
   endfunction

   task automatic report_and_finish();
      $display("summary: %0d errors, %0d of %0d runs, %0d enqueues, %0d dequeues",
               errors, runs_done, n_runs, n_enq, n_deq);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   endtask

   always @(posedge clk) begin : compare
      int  idx;
      int  outstanding;
      bit  exp_rtn;
      bit  matched;
      if (!rst_n) begin
         check_quiet();
         after_rst = 1'b1;
      end else begin
         if (after_rst)
            check_quiet();   // first cycle out of reset
         after_rst = 1'b0;
         if (in_run && settle < 3)
            settle++;

         // registered gvt trails the model by two samples
         if (in_run && settle >= 2) begin
            check_range("gvt", gvt_valid ? gvt_last : 0,
                        (min_prev2 >= 0) ? min_prev2 : 65535, gvt);
            gvt_last  = gvt;
            gvt_valid = 1'b1;
         end

         check_true(!(enq_vld && deq_vld), "enqueue and dequeue in the same cycle");
         check_true(!(prev_strobe && (enq_vld || deq_vld)),
                    "queue strobes in two consecutive cycles");
         prev_strobe = enq_vld || deq_vld;

         if (wait_restart) begin
            if (enq_vld) begin
               check_true(since_rtn <= 2, "init did not restart within 2 cycles of the return");
               wait_restart = 1'b0;
            end else begin
               since_rtn++;
            end
         end

         exp_rtn = in_run && settle >= 3 && gvt_prev > SIM_END_TIME;
         check_eq("rtn_vld", exp_rtn, rtn_vld);

         if (deq_vld) begin
            n_deq++;
            check_true(in_run && !in_init, "dequeue before init completed");
            check_true(model_time.size() > 0, "dequeue while the model queue is empty");
            if (in_run && model_time.size() > 0) begin
               idx = queue_min_idx();
               check_eq("deq_lp", model_lp[idx], deq_lp);
               check_eq("deq_time", model_time[idx], deq_time);
               parents.push_back(model_time[idx]);
               model_lp.delete(idx);
               model_time.delete(idx);
               void'(match_parents(out_min));
            end
         end

         if (enq_vld) begin
            n_enq++;
            if (in_init) begin
               check_eq("enq_lp", init_cnt, enq_lp);
               check_eq("enq_time", 0, enq_time);
               model_lp.push_back(init_cnt);
               model_time.push_back(0);
               init_cnt++;
               if (init_cnt == NUM_LP) begin
                  in_init   = 1'b0;
                  in_run    = 1'b1;
                  settle    = 0;
                  gvt_valid = 1'b0;
                  init_runs++;
               end
            end else if (in_run) begin
               check_true(enq_lp < NUM_LP, "new event targets an LP out of range");
               children.push_back(enq_time);
               matched = match_parents(out_min);
               check_true(matched, $sformatf("new event at time %0d has no parent 1 to 8 earlier",
                                             enq_time));
               if (!matched) begin
                  children.pop_back();   // orphan takes no parent with it
                  void'(match_parents(out_min));
               end
               model_lp.push_back(enq_lp);
               model_time.push_back(enq_time);
            end else begin
               check_true(1'b0, "enqueue outside init and run");
            end
         end

         if (rtn_vld) begin
            runs_done++;
            model_lp.delete();
            model_time.delete();
            parents.delete();
            children.delete();
            out_min      = -1;
            in_run       = 1'b0;
            in_init      = 1'b1;
            init_cnt     = 0;
            wait_restart = 1'b1;
            since_rtn    = 0;
            gvt_valid    = 1'b0;
         end

         if (in_run) begin
            outstanding = parents.size() - children.size();
            check_range("outstanding events", 0, NUM_CORE, outstanding);
            check_eq("queued plus outstanding events", NUM_LP,
                     model_time.size() + outstanding);
         end
         min_prev2 = min_prev1;
         min_prev1 = model_min();
         gvt_prev  = gvt;
      end
   end

   initial begin : stimulus
      void'($urandom(66));
      n_runs = 2 + ($urandom % 2);
      rst_n  = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      // last run is done once the following init has been seen
      wait (init_runs == n_runs + 1);
      repeat (4) @(negedge clk);
      report_and_finish();
   end

   initial begin : watchdog
      wait (n_runs != 0);
      repeat (n_runs * (SIM_END_TIME * 40 + 100)) @(posedge clk);
      $display("timeout: no return strobe arrived, %0d of %0d runs finished",
               runs_done, n_runs);
      errors++;
      report_and_finish();
   end

endmodule

// ==== verilog/phold_top.sv ====
module phold_top import phold_pkg::*; #(
   parameter int NUM_CORE     = 4,
   parameter int NUM_LP       = 16,
   parameter int SIM_END_TIME = 200
) (
   input  logic      clk,
   input  logic      rst_n,
   output sim_time_t gvt,
   output logic      rtn_vld,
   output logic      enq_vld,
   output lp_id_t    enq_lp,
   output sim_time_t enq_time,
   output logic      deq_vld,
   output lp_id_t    deq_lp,
   output sim_time_t deq_time
);

   logic                q_enq, q_deq, q_empty;
   event_t              q_in, q_head;
   logic                running, rng_next, restart;
   rnd_t                rnd;
   logic [NUM_CORE-1:0] core_busy;
   sim_time_t           core_time [NUM_CORE];

   core_if u_cif [NUM_CORE] ();

   event_scheduler #(
      .NUM_CORE     (NUM_CORE),
      .NUM_LP       (NUM_LP),
      .SIM_END_TIME (SIM_END_TIME)
   ) u_sched (
      .clk      (clk),
      .rst_n    (rst_n),
      .q_head   (q_head),
      .q_empty  (q_empty),
      .gvt      (gvt),
      .cores    (u_cif),
      .q_enq    (q_enq),
      .q_deq    (q_deq),
      .q_in     (q_in),
      .running  (running),
      .rng_next (rng_next),
      .restart  (restart),
      .rtn_vld  (rtn_vld)
   );

   // one slot per lp, the event count never grows
   event_queue #(.DEPTH(NUM_LP)) u_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear    (restart),
      .enq      (q_enq),
      .deq      (q_deq),
      .in_event (q_in),
      .head     (q_head),
      .empty    (q_empty)
   );

   lfsr_rng u_rng (
      .clk   (clk),
      .rst_n (rst_n),
      .next  (rng_next),
      .rnd   (rnd)
   );

   gvt_tracker #(.NUM_CORE(NUM_CORE)) u_gvt (
      .clk         (clk),
      .rst_n       (rst_n),
      .running     (running),
      .q_head_time (ev_time(q_head)),
      .q_empty     (q_empty),
      .core_busy   (core_busy),
      .core_time   (core_time),
      .gvt         (gvt)
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : g_core
      phold_core u_core (
         .clk   (clk),
         .rst_n (rst_n),
         .clear (restart),
         .rnd   (rnd),
         .sched (u_cif[g])
      );
      assign core_busy[g] = u_cif[g].busy;
      assign core_time[g] = u_cif[g].busy_time;
   end

   assign enq_vld  = q_enq;
   assign enq_lp   = ev_lp(q_in);
   assign enq_time = ev_time(q_in);
   assign deq_vld  = q_deq;
   assign deq_lp   = ev_lp(q_head);
   assign deq_time = ev_time(q_head);

endmodule

// ==== verilog/event_scheduler.sv ====
module event_scheduler import phold_pkg::*; #(
   parameter  int NUM_CORE     = 4,
   parameter  int NUM_LP       = 16,
   parameter  int SIM_END_TIME = 200,
   localparam int IDX_W        = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1
) (
   input  logic      clk,
   input  logic      rst_n,
   input  event_t    q_head,
   input  logic      q_empty,
   input  sim_time_t gvt,
   core_if.sched     cores [NUM_CORE],
   output logic      q_enq,
   output logic      q_deq,
   output event_t    q_in,
   output logic      running,
   output logic      rng_next,
   output logic      restart,
   output logic      rtn_vld
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_INIT,
      S_READY,
      S_RUNNING,
      S_FINISHED
   } run_state_t;

   run_state_t          state, state_nxt;
   lp_id_t              init_cnt;
   logic                init_done;
   logic                end_reached;
   logic                q_busy;        // idle cycle after each queue op
   logic                ack_rcv;
   logic [NUM_CORE-1:0] new_req, ready_req;
   logic [NUM_CORE-1:0] rcv_gnt, send_gnt;
   logic [IDX_W-1:0]    rcv_idx;
   logic                rcv_vld, send_vld;
   event_t              new_ev [NUM_CORE];

   for (genvar i = 0; i < NUM_CORE; i++) begin : g_core
      assign new_req[i]          = cores[i].new_vld;
      assign ready_req[i]        = cores[i].ready;
      assign new_ev[i]           = cores[i].new_event;
      assign cores[i].disp_vld   = q_deq & send_gnt[i];
      assign cores[i].disp_event = q_head;
      assign cores[i].ack        = ack_rcv & rcv_gnt[i];
   end

   // receive side, cores offering a new event
   rr_arbiter #(.NUM_CORE(NUM_CORE)) u_rcv_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (new_req),
      .advance (ack_rcv),
      .gnt     (rcv_gnt),
      .gnt_idx (rcv_idx),
      .gnt_vld (rcv_vld)
   );

   // send side, idle cores; one-hot grant is enough here
   rr_arbiter #(.NUM_CORE(NUM_CORE)) u_send_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (ready_req),
      .advance (q_deq),
      .gnt     (send_gnt),
      .gnt_idx (),
      .gnt_vld (send_vld)
   );

   // enqueue wins over dequeue
   assign ack_rcv  = !q_busy && (state == S_RUNNING) && rcv_vld;
   assign q_enq    = ack_rcv || (!q_busy && (state == S_INIT));
   assign q_deq    = !q_busy && (state == S_RUNNING) && !rcv_vld && !q_empty && send_vld;
   assign q_in     = (state == S_INIT) ? mk_event(init_cnt, sim_time_t'(0)) : new_ev[rcv_idx];
   assign rng_next = q_deq;

   assign init_done   = (state == S_INIT) && q_enq && (init_cnt == lp_id_t'(NUM_LP - 1));
   assign end_reached = gvt > sim_time_t'(SIM_END_TIME);

   // ready cycle lets the gvt reload from the fresh time-0 queue
   assign running = (state == S_READY) || (state == S_RUNNING);
   assign restart = (state == S_FINISHED);

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE:     state_nxt = S_INIT;
         S_INIT:     if (init_done) state_nxt = S_READY;
         S_READY:    state_nxt = S_RUNNING;
         S_RUNNING:  if (end_reached) state_nxt = S_FINISHED;
         S_FINISHED: state_nxt = S_IDLE;
         default:    state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         rtn_vld  <= 1'b0;
         q_busy   <= 1'b0;
         init_cnt <= '0;
      end else begin
         state   <= state_nxt;
         rtn_vld <= (state == S_RUNNING) && end_reached;   // one cycle, state moves on
         q_busy  <= q_enq | q_deq;
         if (state != S_INIT)
            init_cnt <= '0;
         else if (q_enq)
            init_cnt <= init_cnt + 1'b1;
      end
   end

endmodule

// ==== verilog/gvt_tracker.sv ====
module gvt_tracker import phold_pkg::*; #(
   parameter int NUM_CORE = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                running,
   input  sim_time_t           q_head_time,
   input  logic                q_empty,
   input  logic [NUM_CORE-1:0] core_busy,
   input  sim_time_t           core_time [NUM_CORE],
   output sim_time_t           gvt
);

   sim_time_t last_head;
   logic      last_empty;
   sim_time_t gvt_nxt;

   // previous head covers an event leaving the queue this cycle
   always_comb begin : min_time
      logic found;
      found   = 1'b0;
      gvt_nxt = gvt;   // nothing valid, keep the old value
      if (!q_empty) begin
         found   = 1'b1;
         gvt_nxt = q_head_time;
      end
      if (!last_empty && (!found || last_head < gvt_nxt)) begin
         found   = 1'b1;
         gvt_nxt = last_head;
      end
      for (int i = 0; i < NUM_CORE; i++) begin
         if (core_busy[i] && (!found || core_time[i] < gvt_nxt)) begin
            found   = 1'b1;
            gvt_nxt = core_time[i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_empty <= 1'b1;
         gvt        <= '0;
      end else begin
         last_empty <= q_empty;
         if (running)
            gvt <= gvt_nxt;   // frozen between runs
      end
   end

   always_ff @(posedge clk) begin
      last_head <= q_head_time;
   end

endmodule

// ==== verilog/phold_core.sv ====
module phold_core import phold_pkg::*; (
   input logic clk,
   input logic rst_n,
   input logic clear,
   input rnd_t rnd,
   core_if.core sched
);

   // random word fields: target lp, time increment, execution delay
   localparam int DLY_LSB  = LP_WID;
   localparam int EXEC_LSB = LP_WID + DELAY_WID;

   event_t              cur_ev;
   rnd_t                cur_rnd;
   logic                busy;
   logic                offer;      // new event waiting for ack
   logic [EXEC_WID-1:0] exec_cnt;
   logic                take;

   assign take = sched.disp_vld && !busy;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         offer    <= 1'b0;
         exec_cnt <= '0;
      end else if (clear) begin
         busy     <= 1'b0;
         offer    <= 1'b0;
         exec_cnt <= '0;
      end else if (take) begin
         busy     <= 1'b1;
         exec_cnt <= rnd[EXEC_LSB +: EXEC_WID];
      end else if (busy && !offer) begin
         if (exec_cnt == '0)
            offer <= 1'b1;
         else
            exec_cnt <= exec_cnt - 1'b1;
      end else if (offer && sched.ack) begin
         busy  <= 1'b0;   // back to idle
         offer <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         cur_ev  <= sched.disp_event;
         cur_rnd <= rnd;
      end
   end

   assign sched.ready     = ~busy;
   assign sched.new_vld   = offer;
   assign sched.busy      = busy;
   assign sched.busy_time = ev_time(cur_ev);

   // child lands 1 to 8 after its parent
   assign sched.new_event = mk_event(lp_id_t'(cur_rnd[LP_WID-1:0]),
                                     ev_time(cur_ev)
                                     + sim_time_t'(cur_rnd[DLY_LSB +: DELAY_WID])
                                     + sim_time_t'(1));

endmodule

// ==== verilog/event_queue.sv ====
module event_queue import phold_pkg::*; #(
   parameter  int DEPTH = 16,
   localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   clear,
   input  logic   enq,
   input  logic   deq,
   input  event_t in_event,
   output event_t head,
   output logic   empty
);

   // entries stay packed toward slot 0 in arrival order,
   // so a lower slot is always an older entry
   event_t           mem     [DEPTH];
   event_t           mem_nxt [DEPTH];
   logic [DEPTH-1:0] vld, vld_nxt;
   logic [IDX_W-1:0] head_idx;

   always_comb begin : find_min
      sim_time_t best;
      logic      found;
      best     = '0;
      found    = 1'b0;
      head_idx = '0;
      for (int i = 0; i < DEPTH; i++) begin
         // strict compare keeps the oldest of equal times
         if (vld[i] && (!found || ev_time(mem[i]) < best)) begin
            found    = 1'b1;
            best     = ev_time(mem[i]);
            head_idx = IDX_W'(i);
         end
      end
   end

   assign head  = mem[head_idx];
   assign empty = ~vld[0];   // packed, so slot 0 empty means all empty

   always_comb begin : update
      logic placed;
      mem_nxt = mem;
      vld_nxt = vld;
      placed  = 1'b0;
      if (deq && !empty) begin
         // close the gap left by the head
         for (int i = 0; i < DEPTH - 1; i++) begin
            if (i >= head_idx) begin
               mem_nxt[i] = mem[i+1];
               vld_nxt[i] = vld[i+1];
            end
         end
         vld_nxt[DEPTH-1] = 1'b0;
      end
      if (enq) begin
         for (int i = 0; i < DEPTH; i++) begin
            if (!vld_nxt[i] && !placed) begin   // first free slot
               mem_nxt[i] = in_event;
               vld_nxt[i] = 1'b1;
               placed     = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         vld <= '0;
      else if (clear)
         vld <= '0;
      else
         vld <= vld_nxt;
   end

   always_ff @(posedge clk) begin
      mem <= mem_nxt;
   end

endmodule

// ==== verilog/rr_arbiter.sv ====
module rr_arbiter #(
   parameter  int NUM_CORE = 4,
   localparam int IDX_W    = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [NUM_CORE-1:0] req,
   input  logic                advance,   // grant taken this cycle
   output logic [NUM_CORE-1:0] gnt,
   output logic [IDX_W-1:0]    gnt_idx,
   output logic                gnt_vld
);

   logic [IDX_W-1:0] ptr;   // highest priority requester

   // scan from ptr upward, wrapping around
   always_comb begin : pick
      int unsigned idx;
      gnt     = '0;
      gnt_idx = '0;
      gnt_vld = 1'b0;
      for (int k = 0; k < NUM_CORE; k++) begin
         idx = ptr + k;
         if (idx >= NUM_CORE)
            idx = idx - NUM_CORE;
         if (req[idx] && !gnt_vld) begin
            gnt_vld = 1'b1;
            gnt_idx = IDX_W'(idx);
         end
      end
      if (gnt_vld)
         gnt[gnt_idx] = 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (advance && gnt_vld) begin
         if (gnt_idx == IDX_W'(NUM_CORE - 1))
            ptr <= '0;
         else
            ptr <= gnt_idx + 1'b1;   // winner drops to lowest priority
      end
   end

endmodule

// ==== verilog/lfsr_rng.sv ====
module lfsr_rng import phold_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  logic next,
   output rnd_t rnd
);

   // x^24 + x^23 + x^22 + x^17 + 1, right-shifting Galois form
   localparam rnd_t TAPS = 24'hE1_0000;
   localparam rnd_t SEED = 24'h66_88AA;  // any nonzero value

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rnd <= SEED;
      end else if (next) begin
         if (rnd[0])
            rnd <= (rnd >> 1) ^ TAPS;
         else
            rnd <= rnd >> 1;
      end
   end

endmodule

// ==== verilog/core_if.sv ====
interface core_if import phold_pkg::*;;

   logic      disp_vld;     // single-cycle dispatch strobe
   event_t    disp_event;
   logic      ready;        // core idle
   logic      new_vld;      // held until ack
   event_t    new_event;
   logic      ack;          // single-cycle strobe
   logic      busy;
   sim_time_t busy_time;    // time of the event being worked on

   modport sched (
      output disp_vld, disp_event, ack,
      input  ready, new_vld, new_event, busy, busy_time
   );

   modport core (
      input  disp_vld, disp_event, ack,
      output ready, new_vld, new_event, busy, busy_time
   );

endinterface

// ==== verilog/phold_pkg.sv ====
package phold_pkg;

   localparam int TIME_WID  = 16;
   localparam int LP_WID    = 4;   // up to 16 logical processes
   localparam int RND_WID   = 24;
   localparam int DELAY_WID = 3;   // timestamp increment is 1 + this field
   localparam int EXEC_WID  = 2;   // core execution delay is 1 + this field

   typedef logic [TIME_WID-1:0]        sim_time_t;
   typedef logic [LP_WID-1:0]          lp_id_t;
   typedef logic [LP_WID+TIME_WID-1:0] event_t;  // {target lp, timestamp}
   typedef logic [RND_WID-1:0]         rnd_t;

   function automatic sim_time_t ev_time(event_t ev);
      return ev[TIME_WID-1:0];
   endfunction

   function automatic lp_id_t ev_lp(event_t ev);
      return ev[TIME_WID +: LP_WID];
   endfunction

   function automatic event_t mk_event(lp_id_t lp, sim_time_t t);
      return {lp, t};
   endfunction

endpackage
